//--- hcp.f
+incdir+testbench
common/hcp_pkg.sv
common/hcp_pkt_if.sv
gmii_rx/gmii_rx_framer.sv
pkt_buffer/pkt_buffer.sv
gmii_tx/gmii_tx_serializer.sv
logic/hcp_ctrl.sv
logic/hcp.sv
testbench/tb_hcp.sv

//--- Makefile
BIN  := obj_dir/Vtb_hcp
SRCS := $(filter-out +%,$(shell cat hcp.f)) testbench/tb_hcp_tasks.svh

.PHONY: all run clean

all: run

$(BIN): hcp.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_hcp \
		-f hcp.f -o Vtb_hcp

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_hcp_tasks.svh
// frame send tasks
// reference frame queue
`ifndef TB_HCP_TASKS_SVH
`define TB_HCP_TASKS_SVH

    // payload lengths and bytes of frames that must come out
    int         exp_len_q[$];
    gmii_byte_t exp_byte_q[$];
    int         exp_in;
    int         exp_out;
    int         exp_disc;

    function automatic int random_len(input int lo, input int hi);
        return lo + ({$random(seed)} % (hi - lo + 1));
    endfunction

    //********************
    // GMII receive stimulus
    //********************
    // er is raised on payload byte err_pos, none when negative
    task automatic send_frame(input int len, input int err_pos, input int gap,
                              input logic forward);
        gmii_byte_t payload[$];
        for (int i = 0; i < len; i++) begin
            payload.push_back(gmii_byte_t'($random(seed)));
        end
        for (int i = 0; i < PREAMBLE_LEN + 1 + len; i++) begin
            @(posedge i_gmii_rxclk);
            #2;
            i_gmii_dv = 1'b1;
            i_gmii_er = (err_pos >= 0) && (i == PREAMBLE_LEN + 1 + err_pos);
            if (i < PREAMBLE_LEN) begin
                i_gmii_rxd = PREAMBLE_BYTE;
            end else if (i == PREAMBLE_LEN) begin
                i_gmii_rxd = SFD_BYTE;
            end else begin
                i_gmii_rxd = payload[i - PREAMBLE_LEN - 1];
            end
        end
        // every preamble and SFD pair counts as a received start
        exp_in++;
        if (forward) begin
            exp_len_q.push_back(len);
            exp_out++;
            foreach (payload[i]) begin
                exp_byte_q.push_back(payload[i]);
            end
        end
        repeat (gap) begin
            @(posedge i_gmii_rxclk);
            #2;
            i_gmii_dv  = 1'b0;
            i_gmii_er  = 1'b0;
            i_gmii_rxd = '0;
        end
    endtask

`endif

//--- testbench/tb_hcp.sv
// hardware control point testbench
`default_nettype none

module tb_hcp import hcp_pkg::*; ();

    logic       i_gmii_rxclk;
    logic       i_rst_n;
    logic       i_gmii_dv;
    logic       i_gmii_er;
    gmii_byte_t i_gmii_rxd;
    gmii_byte_t o_gmii_txd;
    logic       o_gmii_tx_en;
    stat_cnt_t  o_inpkt_cnt;
    stat_cnt_t  o_outpkt_cnt;
    stat_cnt_t  o_discard_cnt;

    int         seed;
    int         errors;
    int         timeouts;
    int         checked;
    int         init_frames;
    int         since_rst;
    int         idle_cycles;
    logic       frame_seen;
    gmii_byte_t tx_bytes[$];

    `include "tb_hcp_tasks.svh"

    initial begin
        i_gmii_rxclk = 1'b0;
        forever #20 i_gmii_rxclk = ~i_gmii_rxclk;
    end

    hcp hcp_inst (
        .i_gmii_rxclk  (i_gmii_rxclk),
        .i_rst_n       (i_rst_n),
        .i_gmii_dv     (i_gmii_dv),
        .i_gmii_er     (i_gmii_er),
        .i_gmii_rxd    (i_gmii_rxd),
        .o_gmii_txd    (o_gmii_txd),
        .o_gmii_tx_en  (o_gmii_tx_en),
        .o_inpkt_cnt   (o_inpkt_cnt),
        .o_outpkt_cnt  (o_outpkt_cnt),
        .o_discard_cnt (o_discard_cnt)
    );

    task automatic log_error(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("frames checked %0d, errors %0d, timeouts %0d", checked, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    //********************
    // transmit monitor
    //********************
    task automatic check_frame();
        int         len;
        gmii_byte_t exp;
        assert (exp_len_q.size() != 0)
            else log_error("a frame was transmitted while none was expected");
        if (exp_len_q.size() != 0) begin
            len = exp_len_q.pop_front();
            for (int i = 0; i < PREAMBLE_LEN; i++) begin
                assert (tx_bytes[i] == PREAMBLE_BYTE)
                    else log_error($sformatf("preamble byte %0d is %h", i, tx_bytes[i]));
            end
            assert (tx_bytes[PREAMBLE_LEN] == SFD_BYTE)
                else log_error($sformatf("SFD is %h", tx_bytes[PREAMBLE_LEN]));
            assert (tx_bytes.size() == PREAMBLE_LEN + 1 + len)
                else log_error($sformatf("frame of %0d bytes, expected %0d payload",
                                         tx_bytes.size(), len));
            for (int i = 0; i < len; i++) begin
                exp = exp_byte_q.pop_front();
                assert (tx_bytes[PREAMBLE_LEN + 1 + i] == exp)
                    else log_error($sformatf("payload byte %0d is %h, expected %h",
                                             i, tx_bytes[PREAMBLE_LEN + 1 + i], exp));
            end
            checked++;
        end
    endtask

    always @(negedge i_gmii_rxclk) begin
        if (o_gmii_tx_en) begin
            if (tx_bytes.size() == 0 && frame_seen) begin
                assert (idle_cycles >= IFG_CYCLES)
                    else log_error($sformatf("gap of only %0d idle cycles", idle_cycles));
            end
            tx_bytes.push_back(o_gmii_txd);
            idle_cycles = 0;
        end else begin
            if (tx_bytes.size() != 0) begin
                check_frame();
                tx_bytes.delete();
                frame_seen = 1'b1;
            end
            idle_cycles++;
        end
    end

    // quiet port through reset and init
    always @(negedge i_gmii_rxclk) begin
        if (!i_rst_n) begin
            since_rst = 0;
            assert (o_inpkt_cnt == '0) else log_error("o_inpkt_cnt not zero in reset");
        end else begin
            since_rst++;
        end
        if (since_rst <= INIT_CYCLES + 2) begin
            assert (!o_gmii_tx_en && o_outpkt_cnt == '0 && o_discard_cnt == '0)
                else log_error("transmit or counter activity during reset or init");
        end
    end

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (exp_len_q.size() != 0 && cycles < limit) begin
            @(negedge i_gmii_rxclk);
            cycles++;
        end
        if (exp_len_q.size() != 0) begin
            timeouts++;
            $display("timeout: %0d expected frames never came out on the transmit side",
                     exp_len_q.size());
        end
    endtask

    // counters settle a few cycles after the last eof
    task automatic check_counters();
        repeat (IFG_CYCLES + 4) @(negedge i_gmii_rxclk);
        assert (int'(o_inpkt_cnt) == exp_in)
            else log_error($sformatf("o_inpkt_cnt %0d, expected %0d", o_inpkt_cnt, exp_in));
        assert (int'(o_outpkt_cnt) == exp_out)
            else log_error($sformatf("o_outpkt_cnt %0d, expected %0d", o_outpkt_cnt, exp_out));
        assert (int'(o_discard_cnt) == exp_disc)
            else log_error($sformatf("o_discard_cnt %0d, expected %0d",
                                     o_discard_cnt, exp_disc));
        assert (o_inpkt_cnt == o_outpkt_cnt + o_discard_cnt + stat_cnt_t'(init_frames))
            else log_error("counters do not balance");
    endtask

    //********************
    // test sequence
    //********************
    initial begin
        seed        = 32'h659d;
        errors      = 0;
        timeouts    = 0;
        checked     = 0;
        init_frames = 0;
        since_rst   = 0;
        idle_cycles = 0;
        frame_seen  = 1'b0;
        exp_in      = 0;
        exp_out     = 0;
        exp_disc    = 0;
        i_rst_n     = 1'b0;
        i_gmii_dv   = 1'b0;
        i_gmii_er   = 1'b0;
        i_gmii_rxd  = '0;
        repeat (16) @(posedge i_gmii_rxclk);
        #2;
        i_rst_n = 1'b1;

        // counted but dropped while the port is in init
        repeat (4) @(posedge i_gmii_rxclk);
        send_frame(16, -1, IFG_CYCLES, 1'b0);
        init_frames = 1;
        repeat (INIT_CYCLES) @(posedge i_gmii_rxclk);
        check_counters();

        for (int n = 0; n < 8; n++) begin
            send_frame(random_len(1, 200), -1, IFG_CYCLES + random_len(0, 15), 1'b1);
        end
        wait_drain(6000);
        check_counters();

        // rx error on one payload byte
        send_frame(random_len(8, 80), 3, IFG_CYCLES, 1'b0);
        exp_disc++;
        send_frame(random_len(1, 200), -1, IFG_CYCLES, 1'b1);
        wait_drain(2000);
        check_counters();

        // oversize frame into an empty buffer
        send_frame(600, -1, IFG_CYCLES, 1'b0);
        exp_disc++;
        for (int n = 0; n < 2; n++) begin
            send_frame(random_len(1, 200), -1, IFG_CYCLES, 1'b1);
        end
        wait_drain(2000);
        check_counters();

        // back to back at the minimum input gap
        for (int n = 0; n < 5; n++) begin
            send_frame(random_len(1, 64), -1, IFG_CYCLES, 1'b1);
        end
        wait_drain(2000);
        check_counters();
        finish_run();
    end

endmodule

`default_nettype wire

//--- logic/hcp.sv
// hardware control point
// GMII host port top
`default_nettype none

module hcp import hcp_pkg::*; (
    input  wire logic       i_gmii_rxclk,
    input  wire logic       i_rst_n,
    input  wire logic       i_gmii_dv,
    input  wire logic       i_gmii_er,
    input  wire gmii_byte_t i_gmii_rxd,
    output gmii_byte_t      o_gmii_txd,
    output logic            o_gmii_tx_en,
    output stat_cnt_t       o_inpkt_cnt,
    output stat_cnt_t       o_outpkt_cnt,
    output stat_cnt_t       o_discard_cnt
);

    wire logic w_gmii_rst_n;
    wire logic w_rx_en;
    wire logic w_sof_pulse;
    wire logic w_discard_pulse;
    wire logic w_eof_pulse;

    pkt_wr_if pkt_wr_bus ();
    pkt_rd_if pkt_rd_bus ();

    hcp_ctrl hcp_ctrl_inst (
        .i_gmii_rxclk    (i_gmii_rxclk),
        .i_rst_n         (i_rst_n),
        .i_sof_pulse     (w_sof_pulse),
        .i_discard_pulse (w_discard_pulse),
        .i_eof_pulse     (w_eof_pulse),
        .o_gmii_rst_n    (w_gmii_rst_n),
        .o_rx_en         (w_rx_en),
        .o_inpkt_cnt     (o_inpkt_cnt),
        .o_outpkt_cnt    (o_outpkt_cnt),
        .o_discard_cnt   (o_discard_cnt)
    );

    gmii_rx_framer gmii_rx_framer_inst (
        .i_gmii_rxclk    (i_gmii_rxclk),
        .i_gmii_rst_n    (w_gmii_rst_n),
        .i_gmii_dv       (i_gmii_dv),
        .i_gmii_er       (i_gmii_er),
        .i_gmii_rxd      (i_gmii_rxd),
        .i_rx_en         (w_rx_en),
        .o_wr            (pkt_wr_bus.framer),
        .o_sof_pulse     (w_sof_pulse),
        .o_discard_pulse (w_discard_pulse)
    );

    pkt_buffer pkt_buffer_inst (
        .i_gmii_rxclk    (i_gmii_rxclk),
        .i_gmii_rst_n    (w_gmii_rst_n),
        .i_wr            (pkt_wr_bus.buffer),
        .o_rd            (pkt_rd_bus.buffer)
    );

    gmii_tx_serializer gmii_tx_serializer_inst (
        .i_gmii_rxclk    (i_gmii_rxclk),
        .i_gmii_rst_n    (w_gmii_rst_n),
        .i_rd            (pkt_rd_bus.serializer),
        .o_gmii_txd      (o_gmii_txd),
        .o_gmii_tx_en    (o_gmii_tx_en),
        .o_eof_pulse     (w_eof_pulse)
    );

endmodule

`default_nettype wire

//--- logic/hcp_ctrl.sv
// port control and statistics
`default_nettype none

module hcp_ctrl import hcp_pkg::*; (
    input  wire logic i_gmii_rxclk,
    input  wire logic i_rst_n,
    input  wire logic i_sof_pulse,
    input  wire logic i_discard_pulse,
    input  wire logic i_eof_pulse,
    output logic      o_gmii_rst_n,
    output logic      o_rx_en,
    output stat_cnt_t o_inpkt_cnt,
    output stat_cnt_t o_outpkt_cnt,
    output stat_cnt_t o_discard_cnt
);

    logic [1:0]                     r_rst_sync;
    hcp_state_t                     r_state;
    logic [$clog2(INIT_CYCLES)-1:0] r_init_cnt;

    // async assert, sync release
    always_ff @(posedge i_gmii_rxclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_rst_sync <= 2'b00;
        end else begin
            r_rst_sync <= {r_rst_sync[0], 1'b1};
        end
    end

    assign o_gmii_rst_n = r_rst_sync[1];

    //********************
    // init state
    //********************
    always_ff @(posedge i_gmii_rxclk or negedge o_gmii_rst_n) begin
        if (!o_gmii_rst_n) begin
            r_state    <= HCP_INIT;
            r_init_cnt <= '0;
        end else if (r_state == HCP_INIT) begin
            r_init_cnt <= r_init_cnt + 1'b1;
            if (r_init_cnt == INIT_CYCLES - 1) begin
                r_state <= HCP_RUN;
            end
        end
    end

    assign o_rx_en = (r_state == HCP_RUN);

    // wrapping frame counters
    always_ff @(posedge i_gmii_rxclk or negedge o_gmii_rst_n) begin
        if (!o_gmii_rst_n) begin
            o_inpkt_cnt   <= '0;
            o_outpkt_cnt  <= '0;
            o_discard_cnt <= '0;
        end else begin
            if (i_sof_pulse) begin
                o_inpkt_cnt <= o_inpkt_cnt + 1'b1;
            end
            if (i_eof_pulse) begin
                o_outpkt_cnt <= o_outpkt_cnt + 1'b1;
            end
            if (i_discard_pulse) begin
                o_discard_cnt <= o_discard_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- gmii_tx/gmii_tx_serializer.sv
// GMII transmit serializer
`default_nettype none

module gmii_tx_serializer import hcp_pkg::*; (
    input  wire logic       i_gmii_rxclk,
    input  wire logic       i_gmii_rst_n,
    pkt_rd_if.serializer    i_rd,
    output gmii_byte_t      o_gmii_txd,
    output logic            o_gmii_tx_en,
    output logic            o_eof_pulse
);

    typedef enum logic [2:0] {
        TX_GAP,
        TX_IDLE,
        TX_PRE,
        TX_SFD,
        TX_DATA
    } tx_state_t;

    tx_state_t                     r_state;
    logic [$clog2(IFG_CYCLES)-1:0] r_cnt;
    logic [IDX_W-1:0]              r_idx;

    logic [IDX_W-1:0]              w_last_idx;
    logic                          w_word_end;

    // tail word stops at last_idx
    assign w_last_idx = i_rd.rd_data.tail ? i_rd.rd_data.last_idx : {IDX_W{1'b1}};
    assign w_word_end = (r_state == TX_DATA) && (r_idx == w_last_idx);

    // advance together with the last byte so the next word is ready
    assign i_rd.rd = w_word_end;

    always_ff @(posedge i_gmii_rxclk or negedge i_gmii_rst_n) begin
        if (!i_gmii_rst_n) begin
            r_state      <= TX_IDLE;
            r_cnt        <= '0;
            r_idx        <= '0;
            o_gmii_txd   <= '0;
            o_gmii_tx_en <= 1'b0;
            o_eof_pulse  <= 1'b0;
        end else begin
            o_eof_pulse <= 1'b0;
            case (r_state)
                //********************
                // inter-frame gap
                //********************
                TX_GAP: begin
                    o_gmii_tx_en <= 1'b0;
                    o_gmii_txd   <= '0;
                    o_eof_pulse  <= (r_cnt == '0);
                    if (r_cnt == IFG_CYCLES - 1) begin
                        r_state <= TX_IDLE;
                        r_cnt   <= '0;
                    end else begin
                        r_cnt <= r_cnt + 1'b1;
                    end
                end
                TX_IDLE: begin
                    if (i_rd.frame_ready) begin
                        r_state <= TX_PRE;
                    end
                end
                TX_PRE: begin
                    o_gmii_tx_en <= 1'b1;
                    o_gmii_txd   <= PREAMBLE_BYTE;
                    if (r_cnt == PREAMBLE_LEN - 1) begin
                        r_state <= TX_SFD;
                        r_cnt   <= '0;
                    end else begin
                        r_cnt <= r_cnt + 1'b1;
                    end
                end
                TX_SFD: begin
                    o_gmii_txd <= SFD_BYTE;
                    r_idx      <= '0;
                    r_state    <= TX_DATA;
                end
                //********************
                // payload bytes
                //********************
                TX_DATA: begin
                    o_gmii_txd <= i_rd.rd_data.data[8*(WORD_BYTES-1-r_idx) +: 8];
                    if (w_word_end) begin
                        r_idx <= '0;
                        if (i_rd.rd_data.tail) begin
                            r_state <= TX_GAP;
                        end
                    end else begin
                        r_idx <= r_idx + 1'b1;
                    end
                end
                default: r_state <= TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pkt_buffer/pkt_buffer.sv
// frame buffer with commit and rollback
`default_nettype none

module pkt_buffer import hcp_pkg::*; (
    input  wire logic i_gmii_rxclk,
    input  wire logic i_gmii_rst_n,
    pkt_wr_if.buffer  i_wr,
    pkt_rd_if.buffer  o_rd
);

    pkt_word_t       mem [BUF_DEPTH];

    logic [BUF_AW:0] r_wr_ptr;
    logic [BUF_AW:0] r_cmt_ptr;
    logic [BUF_AW:0] r_rd_ptr;
    logic [BUF_AW:0] r_frm_cnt;

    logic [BUF_AW:0] w_used;
    logic [BUF_AW:0] w_used_next;
    logic            w_tail_rd;

    // count the word still in flight from the framer
    assign w_used      = r_wr_ptr - r_rd_ptr;
    assign w_used_next = w_used + {{BUF_AW{1'b0}}, i_wr.wr};
    assign i_wr.full   = (w_used_next >= BUF_DEPTH);

    assign o_rd.rd_data     = mem[r_rd_ptr[BUF_AW-1:0]];
    assign o_rd.frame_ready = (r_frm_cnt != '0);

    assign w_tail_rd = o_rd.rd && o_rd.rd_data.tail;

    //********************
    // storage
    //********************
    always_ff @(posedge i_gmii_rxclk) begin
        if (i_wr.wr) begin
            mem[r_wr_ptr[BUF_AW-1:0]] <= i_wr.wr_data;
        end
    end

    //********************
    // pointers
    //********************
    always_ff @(posedge i_gmii_rxclk or negedge i_gmii_rst_n) begin
        if (!i_gmii_rst_n) begin
            r_wr_ptr  <= '0;
            r_cmt_ptr <= '0;
            r_rd_ptr  <= '0;
        end else begin
            // rollback to the start of the open frame
            if (i_wr.drop) begin
                r_wr_ptr <= r_cmt_ptr;
            end else if (i_wr.wr) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (i_wr.wr && i_wr.commit) begin
                r_cmt_ptr <= r_wr_ptr + 1'b1;
            end
            if (o_rd.rd) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
        end
    end

    // committed frames waiting for the serializer
    always_ff @(posedge i_gmii_rxclk or negedge i_gmii_rst_n) begin
        if (!i_gmii_rst_n) begin
            r_frm_cnt <= '0;
        end else begin
            case ({i_wr.commit, w_tail_rd})
                2'b10:   r_frm_cnt <= r_frm_cnt + 1'b1;
                2'b01:   r_frm_cnt <= r_frm_cnt - 1'b1;
                default: r_frm_cnt <= r_frm_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- gmii_rx/gmii_rx_framer.sv
// GMII receive framer
`default_nettype none

module gmii_rx_framer import hcp_pkg::*; (
    input  wire logic       i_gmii_rxclk,
    input  wire logic       i_gmii_rst_n,
    input  wire logic       i_gmii_dv,
    input  wire logic       i_gmii_er,
    input  wire gmii_byte_t i_gmii_rxd,
    input  wire logic       i_rx_en,
    pkt_wr_if.framer        o_wr,
    output logic            o_sof_pulse,
    output logic            o_discard_pulse
);

    typedef enum logic {
        RX_IDLE,
        RX_CAPTURE
    } rx_state_t;

    rx_state_t               r_state;
    logic                    r_dv;
    gmii_byte_t              r_rxd;
    logic                    r_active;
    logic                    r_first;
    logic [IDX_W:0]          r_cnt;
    logic [8*WORD_BYTES-1:0] r_acc;

    logic                    w_sof_det;
    logic                    w_capture;
    logic                    w_byte_ok;
    logic                    w_word_due;
    logic                    w_tail_due;
    logic                    w_drop;
    logic [IDX_W-1:0]        w_idx;
    logic [IDX_W-1:0]        w_last_idx;

    // previous byte preamble, current byte SFD
    assign w_sof_det = (r_state == RX_IDLE) && r_dv && (r_rxd == PREAMBLE_BYTE) &&
                       i_gmii_dv && (i_gmii_rxd == SFD_BYTE);

    assign w_capture  = (r_state == RX_CAPTURE) && r_active;
    assign w_byte_ok  = w_capture && i_gmii_dv && !i_gmii_er;
    assign w_word_due = w_byte_ok && (r_cnt == WORD_BYTES);
    assign w_tail_due = w_capture && !i_gmii_dv;

    // rx error, no room, or a frame with no payload at all
    assign w_drop = (w_capture && i_gmii_dv && i_gmii_er) ||
                    ((w_word_due || w_tail_due) && o_wr.full) ||
                    (w_tail_due && (r_cnt == '0));

    // slot 0 again once the word is full
    assign w_idx      = r_cnt[IDX_W-1:0];
    assign w_last_idx = r_cnt[IDX_W-1:0] - 1'b1;

    //********************
    // frame control
    //********************
    always_ff @(posedge i_gmii_rxclk or negedge i_gmii_rst_n) begin
        if (!i_gmii_rst_n) begin
            r_state         <= RX_IDLE;
            r_dv            <= 1'b0;
            r_active        <= 1'b0;
            r_first         <= 1'b0;
            r_cnt           <= '0;
            o_wr.wr         <= 1'b0;
            o_wr.commit     <= 1'b0;
            o_wr.drop       <= 1'b0;
            o_sof_pulse     <= 1'b0;
            o_discard_pulse <= 1'b0;
        end else begin
            r_dv            <= i_gmii_dv;
            o_sof_pulse     <= w_sof_det;
            o_wr.wr         <= 1'b0;
            o_wr.commit     <= 1'b0;
            o_wr.drop       <= 1'b0;
            o_discard_pulse <= 1'b0;
            case (r_state)
                RX_IDLE: begin
                    if (w_sof_det) begin
                        r_state  <= RX_CAPTURE;
                        r_active <= i_rx_en;
                        r_first  <= 1'b1;
                        r_cnt    <= '0;
                    end
                end
                RX_CAPTURE: begin
                    if (!i_gmii_dv) begin
                        r_state  <= RX_IDLE;
                        r_active <= 1'b0;
                    end
                    if (w_drop) begin
                        o_wr.drop       <= 1'b1;
                        o_discard_pulse <= 1'b1;
                        r_active        <= 1'b0;
                    end else if (w_word_due) begin
                        o_wr.wr <= 1'b1;
                        r_first <= 1'b0;
                        r_cnt   <= 1;
                    end else if (w_tail_due) begin
                        o_wr.wr     <= 1'b1;
                        o_wr.commit <= 1'b1;
                    end else if (w_byte_ok) begin
                        r_cnt <= r_cnt + 1'b1;
                    end
                end
                default: r_state <= RX_IDLE;
            endcase
        end
    end

    // full word goes out one byte late
    always_ff @(posedge i_gmii_rxclk) begin
        r_rxd <= i_gmii_rxd;
        if (w_byte_ok) begin
            r_acc[8*(WORD_BYTES-1-w_idx) +: 8] <= i_gmii_rxd;
        end
        if (w_word_due) begin
            o_wr.wr_data <= '{head: r_first, tail: 1'b0, last_idx: {IDX_W{1'b1}}, data: r_acc};
        end else if (w_tail_due) begin
            o_wr.wr_data <= '{head: r_first, tail: 1'b1, last_idx: w_last_idx, data: r_acc};
        end
    end

endmodule

`default_nettype wire

//--- common/hcp_pkt_if.sv
// packet word buses
`default_nettype none

//********************
// write side, framer to buffer
//********************
interface pkt_wr_if import hcp_pkg::*; ();

    pkt_word_t wr_data;
    logic      wr;
    logic      commit;
    logic      drop;
    logic      full;

    modport framer (
        output wr_data,
        output wr,
        output commit,
        output drop,
        input  full
    );

    modport buffer (
        input  wr_data,
        input  wr,
        input  commit,
        input  drop,
        output full
    );

endinterface

//********************
// read side, buffer to serializer
//********************
interface pkt_rd_if import hcp_pkg::*; ();

    pkt_word_t rd_data;
    logic      frame_ready;
    logic      rd;

    modport buffer (
        output rd_data,
        output frame_ready,
        input  rd
    );

    modport serializer (
        input  rd_data,
        input  frame_ready,
        output rd
    );

endinterface

`default_nettype wire

//--- common/hcp_pkg.sv
// hardware control point
// shared constants and types
`default_nettype none

package hcp_pkg;

    // GMII framing
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hd5;
    localparam int         PREAMBLE_LEN  = 7;
    localparam int         IFG_CYCLES    = 12;

    // port control
    localparam int INIT_CYCLES = 64;
    localparam int CNT_W       = 16;

    // packet words and buffer
    localparam int WORD_BYTES = 16;
    localparam int IDX_W      = $clog2(WORD_BYTES);
    localparam int BUF_DEPTH  = 32;
    localparam int BUF_AW     = $clog2(BUF_DEPTH);

    typedef logic [7:0] gmii_byte_t;

    // first payload byte sits in the top byte of data
    typedef struct packed {
        logic                      head;
        logic                      tail;
        logic [IDX_W-1:0]          last_idx;
        logic [8*WORD_BYTES-1:0]   data;
    } pkt_word_t;

    typedef logic [CNT_W-1:0] stat_cnt_t;

    typedef enum logic {
        HCP_INIT,
        HCP_RUN
    } hcp_state_t;

endpackage

`default_nettype wire
